/* project.f */
design/mem_pkg.sv
design/mem_ctrl.sv
design/bus_if.sv
design/mem_reg.sv
design/spm.sv
design/mem_stage.sv
design/mem_top.sv
dv/tb_mem_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the MEM stage testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f project.f --top-module tb_mem_top -o tb_mem_top
./obj_dir/tb_mem_top | tee sim.log
if grep -q "Verification passed" sim.log; then
    echo "run_sim: PASS"
else
    echo "run_sim: FAIL"
    exit 1
fi

/* dv/tb_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_top;

    localparam int NUM_TESTS    = 6;
    localparam int TEST_CYCLES  = 300;
    localparam int LIMIT_CYCLES = NUM_TESTS * TEST_CYCLES + 1200; // 3000 with margin

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       stall;
    logic                       flush;
    mem_pkg::ex_mem_t           ex_in;
    logic [mem_pkg::WORD_W-1:0] fwd_data;
    mem_pkg::mem_wb_t           mem_out;

    ////////////////////////////////////////////////////////////
    // Model state and bookkeeping
    ////////////////////////////////////////////////////////////
    logic [31:0]      rng_state;
    logic [31:0]      shadow [1024];                  // Mirror of SPM contents
    logic             written [1024];                 // Word has been stored
    mem_pkg::mem_wb_t exp_reg;                        // Expected MEM/WB entry
    logic             exp_out_known;                  // Skip out on undefined reads
    string            cur_test;
    int               cycle_cnt = 0;
    int               total_checks;
    int               test_errors;
    int               total_errors;
    int               tests_failed;

    mem_top u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .flush    (flush),
        .ex_in    (ex_in),
        .fwd_data (fwd_data),
        .mem_out  (mem_out)
    );

    always #5 clk = ~clk;                             // 10 ns period

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    initial begin : watchdog
        while (cycle_cnt < LIMIT_CYCLES) begin
            @(posedge clk);
        end
        $display("timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("Verification failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);    // xorshift32
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic chance(input logic [31:0] pct);
        return (next_random() % 32'd100) < pct;
    endfunction

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        total_checks++;
        if (expected !== actual) begin
            $display("mismatch %s %s: expected %h, actual %h", cur_test, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_mem_out();
        compare("mem_out.en", 32'(exp_reg.en), 32'(mem_out.en));
        compare("mem_out.gpr_we", 32'(exp_reg.gpr_we), 32'(mem_out.gpr_we));
        compare("mem_out.exp_code", 32'(exp_reg.exp_code), 32'(mem_out.exp_code));
        if (exp_reg.en) begin                         // Payload only for valid entries
            compare("mem_out.pc", exp_reg.pc, mem_out.pc);
            compare("mem_out.rd_addr", 32'(exp_reg.rd_addr), 32'(mem_out.rd_addr));
            if (exp_out_known) begin
                compare("mem_out.out", exp_reg.out, mem_out.out);
            end
        end
    endtask

    task automatic finish_test(input int cycles);
        if (test_errors == 0) begin
            $display("test %s: ok, %0d cycles", cur_test, cycles);
        end else begin
            $display("test %s: %0d errors in %0d cycles", cur_test, test_errors, cycles);
            tests_failed++;
        end
        total_errors += test_errors;
    endtask

    // One cycle: drive at negedge, check forward path, then the register
    task automatic apply_cycle(input mem_pkg::ex_mem_t ex, input logic st, input logic fl);
        logic        is_ld;
        logic        is_st;
        logic        aligned;
        logic        in_win;
        logic        hit;
        logic        fault;
        logic        new_exp;
        logic [9:0]  idx;
        logic [31:0] fwd_exp;
        logic        fwd_known;
        @(negedge clk);
        ex_in = ex;
        stall = st;
        flush = fl;
        is_ld     = ex.en && (ex.mem_op == mem_pkg::MEM_OP_LDW);
        is_st     = ex.en && (ex.mem_op == mem_pkg::MEM_OP_STW);
        aligned   = (ex.alu_out[1:0] == 2'b00);
        in_win    = (ex.alu_out[31:12] == 20'd0);     // Bytes 0..4095
        idx       = ex.alu_out[11:2];
        hit       = (is_ld || is_st) && aligned && in_win;
        fault     = (is_ld || is_st) && !hit;         // Misaligned or out of window
        new_exp   = fault && (ex.exp_code == mem_pkg::EXP_NONE); // Upstream code wins
        fwd_exp   = is_ld ? (hit ? shadow[idx] : 32'd0) : ex.alu_out;
        fwd_known = !(is_ld && hit && !written[idx]);
        #2;
        if (fwd_known) begin
            compare("fwd_data", fwd_exp, fwd_data);
        end
        @(posedge clk);
        if (!st && fl) begin                          // Bubble, payload held
            exp_reg.en       = 1'b0;
            exp_reg.gpr_we   = 1'b0;
            exp_reg.exp_code = mem_pkg::EXP_NONE;
        end else if (!st) begin
            exp_reg.en       = new_exp ? 1'b1 : ex.en;
            exp_reg.gpr_we   = new_exp ? 1'b0 : ex.gpr_we;
            exp_reg.exp_code = !new_exp ? ex.exp_code :
                               (aligned ? mem_pkg::EXP_BUS_ERR : mem_pkg::EXP_MISS_ALIGN);
            exp_reg.pc       = ex.pc;
            exp_reg.rd_addr  = ex.rd_addr;
            exp_reg.out      = new_exp ? 32'd0 : fwd_exp;
            exp_out_known    = new_exp || fwd_known;
        end
        if (is_st && hit && !fl) begin                // Stores land even under stall
            shadow[idx]  = ex.wr_data;
            written[idx] = 1'b1;
        end
        #1;
        check_mem_out();
    endtask

    task automatic random_test(input string name, input logic [31:0] p_mis,
                               input logic [31:0] p_oob, input logic [31:0] p_stall,
                               input logic [31:0] p_flush);
        mem_pkg::ex_mem_t ex;
        logic [31:0]      r;
        logic             st;
        logic             fl;
        cur_test    = name;
        test_errors = 0;
        for (int i = 0; i < TEST_CYCLES; i++) begin
            r          = next_random();
            ex         = '0;
            ex.en      = (r[2:0] != 3'd0);            // Mostly valid
            ex.mem_op  = (r[5:4] == 2'd0) ? mem_pkg::MEM_OP_NOP :
                         (r[5:4] == 2'd2) ? mem_pkg::MEM_OP_STW : mem_pkg::MEM_OP_LDW;
            ex.rd_addr = r[12:8];
            ex.gpr_we  = ex.en && (ex.mem_op != mem_pkg::MEM_OP_STW);
            if (r[15:13] == 3'd0) begin               // Occasional upstream exception
                ex.exp_code = mem_pkg::exp_code_e'(r[18:16] | 3'd1);
            end
            ex.pc      = next_random();
            ex.wr_data = next_random();
            r          = next_random();
            // Small index range so loads hit stored words
            ex.alu_out = (ex.mem_op == mem_pkg::MEM_OP_NOP) ? r : {24'd0, r[5:0], 2'b00};
            if (chance(p_mis)) begin
                r                = next_random();
                ex.alu_out[1:0]  = (r[1:0] == 2'b00) ? 2'b10 : r[1:0];
            end
            if (chance(p_oob)) begin
                r                = next_random();
                ex.alu_out[31:12] = (r[31:12] == 20'd0) ? 20'd1 : r[31:12];
            end
            st = chance(p_stall);
            fl = chance(p_flush);
            apply_cycle(ex, st, fl);
        end
        finish_test(TEST_CYCLES);
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial begin : main_seq
        mem_pkg::ex_mem_t idle_ex;
        idle_ex      = '0;
        rst_n        = 1'b0;
        stall        = 1'b0;
        flush        = 1'b0;
        ex_in        = '0;
        rng_state    = 32'h9395_449b;
        total_checks = 0;
        total_errors = 0;
        tests_failed = 0;
        for (int i = 0; i < 1024; i++) begin
            written[i] = 1'b0;
        end
        cur_test         = "reset";
        test_errors      = 0;
        exp_reg.en       = 1'b0;
        exp_reg.gpr_we   = 1'b0;
        exp_reg.exp_code = mem_pkg::EXP_NONE;
        exp_out_known    = 1'b0;
        repeat (8) begin                              // Checked while held in reset
            @(posedge clk);
            #1;
            check_mem_out();
        end
        @(negedge clk);
        rst_n = 1'b1;
        repeat (2) apply_cycle(idle_ex, 1'b0, 1'b0);
        finish_test(10);
        random_test("store_load", 32'd0, 32'd0, 32'd0, 32'd0);
        random_test("miss_align", 32'd30, 32'd0, 32'd0, 32'd0);
        random_test("bus_err", 32'd0, 32'd30, 32'd0, 32'd0);
        random_test("stall", 32'd10, 32'd10, 32'd40, 32'd0);
        random_test("flush", 32'd10, 32'd10, 32'd20, 32'd30);
        $display("tests run: %0d, tests failed: %0d, checks: %0d, errors: %0d",
                 NUM_TESTS, tests_failed, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        stall,
    input  logic                        flush,
    input  mem_pkg::ex_mem_t            ex_in,      // EX/MEM record
    output logic [mem_pkg::WORD_W-1:0]  fwd_data,   // Forwarded result
    output mem_pkg::mem_wb_t            mem_out     // MEM/WB record
);

    mem_pkg::spm_req_t          spm_req;            // Stage to SPM
    logic [mem_pkg::WORD_W-1:0] spm_rd_data;        // SPM to stage

    mem_stage u_mem_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .flush       (flush),
        .ex_in       (ex_in),
        .fwd_data    (fwd_data),
        .spm_req     (spm_req),
        .spm_rd_data (spm_rd_data),
        .mem_out     (mem_out)
    );

    spm u_spm (
        .clk         (clk),
        .spm_req     (spm_req),
        .spm_rd_data (spm_rd_data)
    );

endmodule

`default_nettype wire

/* design/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    // Pipeline control
    input  logic                        stall,
    input  logic                        flush,
    // EX/MEM record
    input  mem_pkg::ex_mem_t            ex_in,
    // Forward path
    output logic [mem_pkg::WORD_W-1:0]  fwd_data,      // Combinational result
    // SPM port
    output mem_pkg::spm_req_t           spm_req,
    input  logic [mem_pkg::WORD_W-1:0]  spm_rd_data,
    // MEM/WB record
    output mem_pkg::mem_wb_t            mem_out
);

    ////////////////////////////////////////////////////////////
    // Internal wires
    ////////////////////////////////////////////////////////////
    logic [mem_pkg::WORD_W-1:0]      rd_data;         // bus_if to mem_ctrl
    logic [mem_pkg::WORD_ADDR_W-1:0] addr;            // Word address
    logic                            strobe;
    logic                            write;
    logic [mem_pkg::WORD_W-1:0]      wr_data;
    logic [mem_pkg::WORD_W-1:0]      out;             // Access result
    logic                            miss_align;
    logic                            bus_err;

    assign fwd_data = out;                            // To earlier stages

    mem_ctrl u_mem_ctrl (
        .ex_in      (ex_in),
        .rd_data    (rd_data),
        .strobe     (strobe),
        .write      (write),
        .addr       (addr),
        .wr_data    (wr_data),
        .out        (out),
        .miss_align (miss_align)
    );

    bus_if u_bus_if (
        .flush       (flush),
        .strobe      (strobe),
        .write       (write),
        .addr        (addr),
        .wr_data     (wr_data),
        .rd_data     (rd_data),
        .bus_err     (bus_err),
        .spm_req     (spm_req),
        .spm_rd_data (spm_rd_data)
    );

    mem_reg u_mem_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .flush      (flush),
        .ex_in      (ex_in),
        .out        (out),
        .miss_align (miss_align),
        .bus_err    (bus_err),
        .mem_out    (mem_out)
    );

endmodule

`default_nettype wire

/* design/spm.sv */
`timescale 1ns/1ps
`default_nettype none

module spm (
    input  logic                        clk,
    input  mem_pkg::spm_req_t           spm_req,      // Strobe, write, addr, data
    output logic [mem_pkg::WORD_W-1:0]  spm_rd_data   // Same cycle read
);

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////
    logic [mem_pkg::WORD_W-1:0] mem [mem_pkg::SPM_DEPTH]; // 1024 words, no init

    logic do_write;                                   // Store this cycle

    assign do_write = spm_req.strobe && spm_req.write;

    // Read path is asynchronous so a load completes in its own cycle
    assign spm_rd_data = mem[spm_req.addr];

    ////////////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[spm_req.addr] <= spm_req.wr_data;     // Visible next cycle
        end
    end

    // Address must be resolved whenever an access is requested
    assert property (@(posedge clk) spm_req.strobe |-> !$isunknown(spm_req.addr));

endmodule

`default_nettype wire

/* design/mem_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_reg (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        stall,      // Hold register
    input  logic                        flush,      // Insert bubble
    input  mem_pkg::ex_mem_t            ex_in,
    input  logic [mem_pkg::WORD_W-1:0]  out,        // From mem_ctrl
    input  logic                        miss_align,
    input  logic                        bus_err,
    output mem_pkg::mem_wb_t            mem_out     // MEM/WB record
);

    logic new_exp;                                  // Exception raised here

    assign new_exp = (ex_in.exp_code == mem_pkg::EXP_NONE) && (miss_align || bus_err);

    ////////////////////////////////////////////////////////////
    // MEM/WB register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_out.en       <= 1'b0;               // Bubble
            mem_out.gpr_we   <= 1'b0;
            mem_out.exp_code <= mem_pkg::EXP_NONE;
        end else if (!stall) begin                  // Stall holds everything
            if (flush) begin
                mem_out.en       <= 1'b0;
                mem_out.gpr_we   <= 1'b0;
                mem_out.exp_code <= mem_pkg::EXP_NONE;
            end else if (new_exp) begin
                mem_out.en     <= 1'b1;             // Keep entry for the handler
                mem_out.gpr_we <= 1'b0;             // Suppress writeback
                if (miss_align) begin
                    mem_out.exp_code <= mem_pkg::EXP_MISS_ALIGN; // Wins over bus error
                end else begin
                    mem_out.exp_code <= mem_pkg::EXP_BUS_ERR;
                end
                mem_out.pc      <= ex_in.pc;
                mem_out.rd_addr <= ex_in.rd_addr;
                mem_out.out     <= '0;              // No valid result
            end else begin
                mem_out.en       <= ex_in.en;
                mem_out.gpr_we   <= ex_in.gpr_we;
                mem_out.exp_code <= ex_in.exp_code; // Upstream code passes through
                mem_out.pc       <= ex_in.pc;
                mem_out.rd_addr  <= ex_in.rd_addr;
                mem_out.out      <= out;
            end
        end
    end

    // Writeback only ever comes with a valid entry
    assert property (@(posedge clk) disable iff (!rst_n) mem_out.gpr_we |-> mem_out.en);

endmodule

`default_nettype wire

/* design/bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_if (
    input  logic                             flush,       // Cancel this access
    // CPU side
    input  logic                             strobe,
    input  logic                             write,
    input  logic [mem_pkg::WORD_ADDR_W-1:0]  addr,
    input  logic [mem_pkg::WORD_W-1:0]       wr_data,
    output logic [mem_pkg::WORD_W-1:0]       rd_data,
    output logic                             bus_err,     // Outside SPM window
    // SPM side
    output mem_pkg::spm_req_t                spm_req,
    input  logic [mem_pkg::WORD_W-1:0]       spm_rd_data
);

    logic in_window;                                     // Address hits SPM
    logic hit;                                           // Strobe inside window

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////
    assign in_window = (addr[mem_pkg::WORD_ADDR_W-1:mem_pkg::SPM_ADDR_W]
                        == mem_pkg::SPM_BASE);
    assign hit       = strobe && in_window;
    assign bus_err   = strobe && !in_window;             // Never forwarded

    ////////////////////////////////////////////////////////////
    // SPM request, blocked by flush
    ////////////////////////////////////////////////////////////
    always_comb begin
        spm_req.strobe  = hit && !flush;
        spm_req.write   = hit && !flush && write;        // No write on flush
        spm_req.addr    = addr[mem_pkg::SPM_ADDR_W-1:0]; // Word index in window
        spm_req.wr_data = wr_data;
    end

    // Read data only for a strobe that reached the window
    assign rd_data = hit ? spm_rd_data : '0;

endmodule

`default_nettype wire

/* design/mem_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl (
    input  mem_pkg::ex_mem_t                 ex_in,      // EX/MEM record
    input  logic [mem_pkg::WORD_W-1:0]       rd_data,    // From bus_if
    output logic                             strobe,     // CPU side request
    output logic                             write,      // Store when high
    output logic [mem_pkg::WORD_ADDR_W-1:0]  addr,       // Word address
    output logic [mem_pkg::WORD_W-1:0]       wr_data,
    output logic [mem_pkg::WORD_W-1:0]       out,        // Stage result
    output logic                             miss_align  // Unaligned access
);

    ////////////////////////////////////////////////////////////
    // Operation decode
    ////////////////////////////////////////////////////////////
    logic is_load;                                       // Valid LDW
    logic is_store;                                      // Valid STW
    logic aligned;                                       // Byte offset zero

    assign is_load  = ex_in.en && (ex_in.mem_op == mem_pkg::MEM_OP_LDW);
    assign is_store = ex_in.en && (ex_in.mem_op == mem_pkg::MEM_OP_STW);
    assign aligned  = (ex_in.alu_out[1:0] == 2'b00);     // Word boundary

    ////////////////////////////////////////////////////////////
    // Request to bus_if
    ////////////////////////////////////////////////////////////
    assign miss_align = (is_load || is_store) && !aligned;
    assign strobe     = (is_load || is_store) && aligned; // No access when unaligned
    assign write      = is_store && aligned;
    assign addr       = ex_in.alu_out[mem_pkg::WORD_W-1:2]; // Drop byte offset
    assign wr_data    = ex_in.wr_data;

    ////////////////////////////////////////////////////////////
    // Result select
    ////////////////////////////////////////////////////////////
    always_comb begin
        out = ex_in.alu_out;                             // NOP and store
        if (is_load) begin
            if (aligned) begin
                out = rd_data;                           // Loaded word
            end else begin
                out = '0;                                // Faulting load
            end
        end
    end

endmodule

`default_nettype wire

/* design/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////
    localparam int WORD_W      = 32;                      // Data word
    localparam int WORD_ADDR_W = 30;                      // Word address, byte addr [31:2]
    localparam int REG_ADDR_W  = 5;                       // GPR index
    localparam int SPM_ADDR_W  = 10;                      // SPM word index
    localparam int SPM_DEPTH   = 1 << SPM_ADDR_W;         // 1024 words
    localparam int SPM_BASE_W  = WORD_ADDR_W - SPM_ADDR_W; // Window select bits

    // Window select, word address [29:10]; zero maps bytes 0..4095
    localparam logic [SPM_BASE_W-1:0] SPM_BASE = '0;

    ////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        MEM_OP_NOP = 2'd0,                                // Pass ALU result
        MEM_OP_LDW = 2'd1,                                // Load word
        MEM_OP_STW = 2'd2                                 // Store word
    } mem_op_e;

    // Other codes from upstream stages pass through untouched
    typedef enum logic [2:0] {
        EXP_NONE       = 3'd0,
        EXP_MISS_ALIGN = 3'd4,                            // Unaligned word access
        EXP_BUS_ERR    = 3'd7                             // Outside SPM window
    } exp_code_e;

    ////////////////////////////////////////////////////////////
    // Records
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic                  en;                        // Entry valid
        exp_code_e             exp_code;
        logic [WORD_W-1:0]     pc;
        mem_op_e               mem_op;
        logic [WORD_W-1:0]     wr_data;                   // Store data
        logic [REG_ADDR_W-1:0] rd_addr;                   // Destination GPR
        logic                  gpr_we;                    // GPR write enable
        logic [WORD_W-1:0]     alu_out;                   // EX result or address
    } ex_mem_t;                                           // 108 bits

    typedef struct packed {
        logic                  en;
        exp_code_e             exp_code;
        logic [WORD_W-1:0]     pc;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic                  gpr_we;
        logic [WORD_W-1:0]     out;                       // Stage result
    } mem_wb_t;                                           // 74 bits

    typedef struct packed {
        logic                  strobe;                    // Access request
        logic                  write;                     // 1 store, 0 load
        logic [SPM_ADDR_W-1:0] addr;                      // Word index
        logic [WORD_W-1:0]     wr_data;
    } spm_req_t;

endpackage

`default_nettype wire
